// ==== include/axis2axi_params.svh ====
`ifndef AXIS2AXI_PARAMS_SVH
`define AXIS2AXI_PARAMS_SVH

// Byte address width of the AXI port
`define AXIS2AXI_ADDR_W 16

// Only 4 byte words are moved
`define AXIS2AXI_DATA_W 32

// Maximum burst is 2**BURST_W beats
`define AXIS2AXI_BURST_W 3

// Input FIFO holds 2**FIFO_W words
`define AXIS2AXI_FIFO_W 4

`endif

// ==== source/axis2axi_pkg.sv ====
`default_nettype none

`include "axis2axi_params.svh"

package axis2axi_pkg;

  typedef logic [`AXIS2AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXIS2AXI_DATA_W-1:0] word_t;
  typedef logic [`AXIS2AXI_ADDR_W-1:0] wlen_t;
  // Beats per burst, 1 up to the maximum burst
  typedef logic [`AXIS2AXI_BURST_W:0] blen_t;
  typedef logic [7:0] axlen_t;

  typedef struct packed {
    addr_t addr;
    wlen_t len;
  } dma_cfg_t;

  // Shared by AR and AW
  typedef struct packed {
    addr_t  addr;
    axlen_t len;
  } ax_req_t;

  // Shared by R and W
  typedef struct packed {
    word_t data;
    logic  last;
  } data_beat_t;

  typedef enum logic [1:0] {
    RD_WAIT_START,
    RD_BEGIN_LOCAL,
    RD_TRANSFER,
    RD_END_LOCAL
  } rd_state_t;

  typedef enum logic [2:0] {
    WR_WAIT_START,
    WR_BEGIN_LOCAL,
    WR_FILL,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_t;

endpackage

`default_nettype wire

// ==== source/axis2axi_burst_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis2axi_params.svh"

module axis2axi_burst_calc (
  input  axis2axi_pkg::addr_t addr_i,
  input  axis2axi_pkg::wlen_t remaining_i,
  output axis2axi_pkg::blen_t burst_o
);
  import axis2axi_pkg::*;

  localparam wlen_t MAX_BURST = wlen_t'(1 << `AXIS2AXI_BURST_W);

  logic [12:0] to_boundary_bytes;
  wlen_t       to_boundary;
  wlen_t       limit;

  always_comb begin
    // Bytes left in the current 4 KiB page, 1 to 4096
    to_boundary_bytes = 13'h1000 - {1'b0, addr_i[11:0]};
    to_boundary = wlen_t'(to_boundary_bytes[12:2]);

    if (remaining_i < MAX_BURST) begin
      limit = remaining_i;
    end else begin
      limit = MAX_BURST;
    end

    // Never cross the page
    if (to_boundary < limit) begin
      limit = to_boundary;
    end
  end

  assign burst_o = blen_t'(limit);

endmodule

`default_nettype wire

// ==== source/axis2axi_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis2axi_fifo #(
  parameter int DEPTH_W = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axis2axi_pkg::word_t wr_data_i,
  input  logic                wr_valid_i,
  output logic                wr_ready_o,
  output axis2axi_pkg::word_t rd_data_o,
  input  logic                rd_pop_i,
  output axis2axi_pkg::wlen_t count_o
);
  import axis2axi_pkg::*;

  localparam int DEPTH = 1 << DEPTH_W;

  word_t              mem [DEPTH];
  logic [DEPTH_W-1:0] wr_ptr;
  logic [DEPTH_W-1:0] rd_ptr;
  logic [DEPTH_W:0]   count;
  logic               do_push;
  logic               do_pop;

  // Full exactly when the top count bit is set
  assign wr_ready_o = ~count[DEPTH_W];
  assign do_push = wr_valid_i && wr_ready_o;
  assign do_pop = rd_pop_i && (count != '0);

  assign rd_data_o = mem[rd_ptr];
  assign count_o = wlen_t'(count);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/axis2axi_in.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis2axi_in (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Job configuration
  input  axis2axi_pkg::dma_cfg_t   cfg_i,
  input  logic                     cfg_valid_i,
  output logic                     cfg_ready_o,
  // Burst sizing
  output axis2axi_pkg::addr_t      burst_addr_o,
  output axis2axi_pkg::wlen_t      burst_remaining_o,
  input  axis2axi_pkg::blen_t      burst_i,
  // Buffered input words
  input  axis2axi_pkg::word_t      fifo_data_i,
  input  axis2axi_pkg::wlen_t      fifo_count_i,
  output logic                     fifo_pop_o,
  // AXI write channels
  output axis2axi_pkg::ax_req_t    aw_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  output axis2axi_pkg::data_beat_t w_o,
  output logic                     w_valid_o,
  input  logic                     w_ready_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o
);
  import axis2axi_pkg::*;

  wr_state_t state;
  wr_state_t state_nxt;
  addr_t     cur_addr;
  addr_t     addr_nxt;
  wlen_t     cur_len;
  wlen_t     len_nxt;
  blen_t     burst_len;
  blen_t     beat_cnt;
  blen_t     last_beat;
  logic      w_last;
  logic      w_hs;

  assign last_beat = burst_len - blen_t'(1);
  assign w_last = (beat_cnt == last_beat);
  assign w_hs = w_valid_o && w_ready_i;

  assign cfg_ready_o = (state == WR_WAIT_START);
  assign burst_addr_o = cur_addr;
  assign burst_remaining_o = cur_len;

  assign aw_o = '{addr: cur_addr, len: axlen_t'(last_beat)};
  assign aw_valid_o = (state == WR_ADDR);

  // FIFO already holds the whole burst, so W never starves
  assign w_o = '{data: fifo_data_i, last: w_last};
  assign w_valid_o = (state == WR_DATA);
  assign fifo_pop_o = w_hs;

  assign b_ready_o = (state == WR_RESP);

  always_comb begin
    state_nxt = state;
    addr_nxt = cur_addr;
    len_nxt = cur_len;
    case (state)
      WR_WAIT_START: begin
        if (cfg_valid_i) begin
          addr_nxt = cfg_i.addr;
          len_nxt = cfg_i.len;
          if (cfg_i.len != '0) begin
            state_nxt = WR_BEGIN_LOCAL;
          end
        end
      end
      WR_BEGIN_LOCAL: begin
        len_nxt = cur_len - wlen_t'(burst_i);
        state_nxt = WR_FILL;
      end
      WR_FILL: begin
        if (fifo_count_i >= wlen_t'(burst_len)) begin
          state_nxt = WR_ADDR;
        end
      end
      WR_ADDR: begin
        if (aw_ready_i) begin
          state_nxt = WR_DATA;
        end
      end
      WR_DATA: begin
        if (w_hs && w_last) begin
          state_nxt = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_valid_i) begin
          // 4 bytes per beat
          addr_nxt = cur_addr + addr_t'({burst_len, 2'b00});
          if (cur_len == '0) begin
            state_nxt = WR_WAIT_START;
          end else begin
            state_nxt = WR_BEGIN_LOCAL;
          end
        end
      end
      default: state_nxt = WR_WAIT_START;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state     <= WR_WAIT_START;
      cur_addr  <= '0;
      cur_len   <= '0;
      burst_len <= '0;
      beat_cnt  <= '0;
    end else begin
      state    <= state_nxt;
      cur_addr <= addr_nxt;
      cur_len  <= len_nxt;
      if (state == WR_BEGIN_LOCAL) begin
        burst_len <= burst_i;
      end
      if (state == WR_ADDR) begin
        beat_cnt <= '0;
      end else if (w_hs) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/axis2axi_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis2axi_out (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Job configuration
  input  axis2axi_pkg::dma_cfg_t   cfg_i,
  input  logic                     cfg_valid_i,
  output logic                     cfg_ready_o,
  // Burst sizing
  output axis2axi_pkg::addr_t      burst_addr_o,
  output axis2axi_pkg::wlen_t      burst_remaining_o,
  input  axis2axi_pkg::blen_t      burst_i,
  // AXI read channels
  output axis2axi_pkg::ax_req_t    ar_o,
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  input  axis2axi_pkg::data_beat_t r_i,
  input  logic                     r_valid_i,
  output logic                     r_ready_o,
  // Output stream
  output axis2axi_pkg::word_t      stream_data_o,
  output logic                     stream_valid_o,
  input  logic                     stream_ready_i
);
  import axis2axi_pkg::*;

  rd_state_t state;
  rd_state_t state_nxt;
  addr_t     cur_addr;
  addr_t     addr_nxt;
  wlen_t     cur_len;
  wlen_t     len_nxt;
  axlen_t    arlen;
  addr_t     burst_bytes;
  logic      in_burst;
  logic      r_last_hs;

  assign in_burst = (state == RD_END_LOCAL);
  assign r_last_hs = in_burst && r_valid_i && stream_ready_i && r_i.last;
  assign burst_bytes = (addr_t'(arlen) + addr_t'(1)) << 2;

  assign cfg_ready_o = (state == RD_WAIT_START);
  assign burst_addr_o = cur_addr;
  assign burst_remaining_o = cur_len;

  assign ar_o = '{addr: cur_addr, len: arlen};
  assign ar_valid_o = (state == RD_TRANSFER);

  // R beats pass straight through while a burst is open
  assign stream_data_o = r_i.data;
  assign stream_valid_o = in_burst && r_valid_i;
  assign r_ready_o = in_burst && stream_ready_i;

  always_comb begin
    state_nxt = state;
    addr_nxt = cur_addr;
    len_nxt = cur_len;
    case (state)
      RD_WAIT_START: begin
        if (cfg_valid_i) begin
          addr_nxt = cfg_i.addr;
          len_nxt = cfg_i.len;
          if (cfg_i.len != '0) begin
            state_nxt = RD_BEGIN_LOCAL;
          end
        end
      end
      RD_BEGIN_LOCAL: begin
        len_nxt = cur_len - wlen_t'(burst_i);
        state_nxt = RD_TRANSFER;
      end
      RD_TRANSFER: begin
        if (ar_ready_i) begin
          state_nxt = RD_END_LOCAL;
        end
      end
      RD_END_LOCAL: begin
        if (r_last_hs) begin
          addr_nxt = cur_addr + burst_bytes;
          if (cur_len == '0) begin
            state_nxt = RD_WAIT_START;
          end else begin
            state_nxt = RD_BEGIN_LOCAL;
          end
        end
      end
      default: state_nxt = RD_WAIT_START;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state    <= RD_WAIT_START;
      cur_addr <= '0;
      cur_len  <= '0;
      arlen    <= '0;
    end else begin
      state    <= state_nxt;
      cur_addr <= addr_nxt;
      cur_len  <= len_nxt;
      // AXI len is beats minus one
      if (state == RD_BEGIN_LOCAL) begin
        arlen <= axlen_t'(burst_i - blen_t'(1));
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/axis2axi.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis2axi_params.svh"

module axis2axi (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Stream to memory job
  input  axis2axi_pkg::dma_cfg_t   cfg_in_i,
  input  logic                     cfg_in_valid_i,
  output logic                     cfg_in_ready_o,
  // Memory to stream job
  input  axis2axi_pkg::dma_cfg_t   cfg_out_i,
  input  logic                     cfg_out_valid_i,
  output logic                     cfg_out_ready_o,
  // Streams
  input  axis2axi_pkg::word_t      axis_in_data_i,
  input  logic                     axis_in_valid_i,
  output logic                     axis_in_ready_o,
  output axis2axi_pkg::word_t      axis_out_data_o,
  output logic                     axis_out_valid_o,
  input  logic                     axis_out_ready_i,
  // AXI master
  output axis2axi_pkg::ax_req_t    aw_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  output axis2axi_pkg::data_beat_t w_o,
  output logic                     w_valid_o,
  input  logic                     w_ready_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o,
  output axis2axi_pkg::ax_req_t    ar_o,
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  input  axis2axi_pkg::data_beat_t r_i,
  input  logic                     r_valid_i,
  output logic                     r_ready_o
);
  import axis2axi_pkg::*;

  word_t fifo_data;
  wlen_t fifo_count;
  logic  fifo_pop;

  addr_t in_burst_addr;
  wlen_t in_burst_remaining;
  blen_t in_burst;
  addr_t out_burst_addr;
  wlen_t out_burst_remaining;
  blen_t out_burst;

  // Input stream is buffered so whole bursts can be written
  axis2axi_fifo #(
    .DEPTH_W(`AXIS2AXI_FIFO_W)
  ) fifo_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_data_i (axis_in_data_i),
    .wr_valid_i(axis_in_valid_i),
    .wr_ready_o(axis_in_ready_o),
    .rd_data_o (fifo_data),
    .rd_pop_i  (fifo_pop),
    .count_o   (fifo_count)
  );

  axis2axi_burst_calc in_calc_i (
    .addr_i     (in_burst_addr),
    .remaining_i(in_burst_remaining),
    .burst_o    (in_burst)
  );

  axis2axi_burst_calc out_calc_i (
    .addr_i     (out_burst_addr),
    .remaining_i(out_burst_remaining),
    .burst_o    (out_burst)
  );

  axis2axi_in in_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_i            (cfg_in_i),
    .cfg_valid_i      (cfg_in_valid_i),
    .cfg_ready_o      (cfg_in_ready_o),
    .burst_addr_o     (in_burst_addr),
    .burst_remaining_o(in_burst_remaining),
    .burst_i          (in_burst),
    .fifo_data_i      (fifo_data),
    .fifo_count_i     (fifo_count),
    .fifo_pop_o       (fifo_pop),
    .aw_o             (aw_o),
    .aw_valid_o       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .w_o              (w_o),
    .w_valid_o        (w_valid_o),
    .w_ready_i        (w_ready_i),
    .b_valid_i        (b_valid_i),
    .b_ready_o        (b_ready_o)
  );

  axis2axi_out out_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_i            (cfg_out_i),
    .cfg_valid_i      (cfg_out_valid_i),
    .cfg_ready_o      (cfg_out_ready_o),
    .burst_addr_o     (out_burst_addr),
    .burst_remaining_o(out_burst_remaining),
    .burst_i          (out_burst),
    .ar_o             (ar_o),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .r_i              (r_i),
    .r_valid_i        (r_valid_i),
    .r_ready_o        (r_ready_o),
    .stream_data_o    (axis_out_data_o),
    .stream_valid_o   (axis_out_valid_o),
    .stream_ready_i   (axis_out_ready_i)
  );

endmodule

`default_nettype wire

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  axis2axi_pkg::ax_req_t    aw_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  axis2axi_pkg::data_beat_t w_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  input  axis2axi_pkg::ax_req_t    ar_i,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  output axis2axi_pkg::data_beat_t r_o,
  output logic                     r_valid_o,
  input  logic                     r_ready_i
);
  import axis2axi_pkg::*;

  word_t  mem [16384];
  int     wr_log_addr[$];
  int     wr_log_beats[$];
  int     rd_log_addr[$];
  int     rd_log_beats[$];
  integer seed = 32'hcf75_db7e;
  addr_t  w_addr;
  addr_t  r_addr;
  int     r_left;
  logic   w_active;
  logic   b_pend;
  logic   r_active;
  logic   r_taken;

  // Ready or valid about three cycles in four
  function automatic logic roll_ready();
    return ($random(seed) & 3) != 0;
  endfunction

  initial begin
    for (int i = 0; i < 16384; i++) begin
      mem[i] = {16'(i) ^ 16'hc3a5, 16'(i)};
    end
  end

  // Handshakes are taken at the rising edge
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      w_active <= 1'b0;
      b_pend   <= 1'b0;
      r_active <= 1'b0;
      r_taken  <= 1'b0;
    end else begin
      r_taken <= r_valid_o && r_ready_i;
      if (aw_valid_i && aw_ready_o) begin
        w_addr   <= aw_i.addr;
        w_active <= 1'b1;
        wr_log_addr.push_back(int'(aw_i.addr));
        wr_log_beats.push_back(int'(aw_i.len) + 1);
      end
      if (w_valid_i && w_ready_o) begin
        mem[w_addr[15:2]] <= w_i.data;
        w_addr <= w_addr + 16'd4;
        if (w_i.last) begin
          w_active <= 1'b0;
          b_pend   <= 1'b1;
        end
      end
      if (b_valid_o && b_ready_i) begin
        b_pend <= 1'b0;
      end
      if (ar_valid_i && ar_ready_o) begin
        r_addr   <= ar_i.addr;
        r_left   <= int'(ar_i.len) + 1;
        r_active <= 1'b1;
        rd_log_addr.push_back(int'(ar_i.addr));
        rd_log_beats.push_back(int'(ar_i.len) + 1);
      end
      if (r_valid_o && r_ready_i) begin
        r_addr <= r_addr + 16'd4;
        r_left <= r_left - 1;
        if (r_left == 1) begin
          r_active <= 1'b0;
        end
      end
    end
  end

  // Outputs change at the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_o        <= '0;
    end else begin
      aw_ready_o <= !w_active && !b_pend && roll_ready();
      w_ready_o  <= w_active && roll_ready();
      b_valid_o  <= b_pend;
      ar_ready_o <= !r_active && roll_ready();
      // A raised R valid holds until taken
      if (!(r_valid_o && !r_taken)) begin
        r_valid_o <= r_active && roll_ready();
      end
      r_o <= '{data: mem[r_addr[15:2]], last: (r_left == 1)};
    end
  end

endmodule

`default_nettype wire

// ==== bench/axis2axi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis2axi_tb;
  import axis2axi_pkg::*;

  localparam int JOB_WORDS = 90;
  localparam int CYCLES_PER_WORD = 40;
  localparam int JOB_CYCLES = 2000;
  localparam int TIMEOUT_NS = (JOB_WORDS * CYCLES_PER_WORD + 200) * 4;

  logic       clk;
  logic       rst_n;
  dma_cfg_t   cfg_in;
  logic       cfg_in_valid;
  logic       cfg_in_ready;
  dma_cfg_t   cfg_out;
  logic       cfg_out_valid;
  logic       cfg_out_ready;
  word_t      in_data;
  logic       in_valid;
  logic       in_ready;
  word_t      out_data;
  logic       out_valid;
  logic       out_ready;
  ax_req_t    aw;
  logic       aw_valid;
  logic       aw_ready;
  data_beat_t w;
  logic       w_valid;
  logic       w_ready;
  logic       b_valid;
  logic       b_ready;
  ax_req_t    ar;
  logic       ar_valid;
  logic       ar_ready;
  data_beat_t r;
  logic       r_valid;
  logic       r_ready;

  integer seed = 32'hcf75_db7e;
  logic   rand_ready;
  word_t  rx_q[$];
  word_t  wr_q[$];
  word_t  split_q[$];
  int     errors;
  int     checks;
  int     tests;

  axis2axi dut_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .cfg_in_i(cfg_in), .cfg_in_valid_i(cfg_in_valid), .cfg_in_ready_o(cfg_in_ready),
    .cfg_out_i(cfg_out), .cfg_out_valid_i(cfg_out_valid), .cfg_out_ready_o(cfg_out_ready),
    .axis_in_data_i(in_data), .axis_in_valid_i(in_valid), .axis_in_ready_o(in_ready),
    .axis_out_data_o(out_data), .axis_out_valid_o(out_valid), .axis_out_ready_i(out_ready),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_ready_o(b_ready),
    .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready)
  );

  axi_mem_model mem_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
  end

  // Output stream words are taken at the rising edge
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      rx_q.push_back(out_data);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic start_job(input bit rd, input addr_t addr, input wlen_t len);
    if (rd) begin
      cfg_out = '{addr: addr, len: len};
      cfg_out_valid = 1'b1;
      while (!cfg_out_ready) @(negedge clk);
      @(negedge clk);
      cfg_out_valid = 1'b0;
    end else begin
      cfg_in = '{addr: addr, len: len};
      cfg_in_valid = 1'b1;
      while (!cfg_in_ready) @(negedge clk);
      @(negedge clk);
      cfg_in_valid = 1'b0;
    end
  endtask

  task automatic wait_done(input bit rd);
    int n = 0;
    while (!(rd ? cfg_out_ready : cfg_in_ready) && n < JOB_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (n >= JOB_CYCLES) begin
      $display("Job did not return to idle within %0d cycles", JOB_CYCLES);
      errors++;
    end
  endtask

  task automatic send_words(input word_t q[$]);
    foreach (q[i]) begin
      in_data = q[i];
      in_valid = 1'b1;
      while (!in_ready) @(negedge clk);
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic make_words(input int n, output word_t q[$]);
    q = {};
    for (int i = 0; i < n; i++) begin
      q.push_back($random(seed));
    end
  endtask

  task automatic check_burst(input bit rd, input int idx, input int addr, input int beats);
    if (rd) begin
      check_eq("ar burst addr", mem_i.rd_log_addr[idx], addr);
      check_eq("ar burst beats", mem_i.rd_log_beats[idx], beats);
    end else begin
      check_eq("aw burst addr", mem_i.wr_log_addr[idx], addr);
      check_eq("aw burst beats", mem_i.wr_log_beats[idx], beats);
    end
  endtask

  task automatic check_rx(input word_t exp[$]);
    check_eq("rx word count", rx_q.size(), exp.size());
    foreach (exp[i]) begin
      if (i < rx_q.size()) begin
        check_eq("axis_out_data_o", rx_q[i], exp[i]);
      end
    end
  endtask

  task automatic write_job(input addr_t addr, input word_t q[$]);
    start_job(1'b0, addr, wlen_t'(q.size()));
    send_words(q);
    wait_done(1'b0);
  endtask

  task automatic read_job(input addr_t addr, input int n);
    rx_q = {};
    start_job(1'b1, addr, wlen_t'(n));
    wait_done(1'b1);
    @(negedge clk);
  endtask

  task automatic test_reset_state();
    int e = errors;
    check_eq("cfg_in_ready_o", 32'(cfg_in_ready), 1);
    check_eq("cfg_out_ready_o", 32'(cfg_out_ready), 1);
    // Empty FIFO takes input words
    check_eq("axis_in_ready_o", 32'(in_ready), 1);
    check_eq("aw_valid_o", 32'(aw_valid), 0);
    check_eq("w_valid_o", 32'(w_valid), 0);
    check_eq("ar_valid_o", 32'(ar_valid), 0);
    check_eq("axis_out_valid_o", 32'(out_valid), 0);
    check_eq("r_ready_o", 32'(r_ready), 0);
    check_eq("b_ready_o", 32'(b_ready), 0);
    check_eq("write bursts", mem_i.wr_log_addr.size(), 0);
    check_eq("read bursts", mem_i.rd_log_addr.size(), 0);
    finish_test("reset_state", e);
  endtask

  task automatic test_zero_length();
    int e = errors;
    start_job(1'b0, 16'h0200, '0);
    wait_done(1'b0);
    start_job(1'b1, 16'h0200, '0);
    wait_done(1'b1);
    repeat (4) @(negedge clk);
    check_eq("cfg_in_ready_o", 32'(cfg_in_ready), 1);
    check_eq("cfg_out_ready_o", 32'(cfg_out_ready), 1);
    check_eq("write bursts", mem_i.wr_log_addr.size(), 0);
    check_eq("read bursts", mem_i.rd_log_addr.size(), 0);
    finish_test("zero_length", e);
  endtask

  task automatic test_write_path();
    int e = errors;
    make_words(20, wr_q);
    write_job(16'h0100, wr_q);
    check_eq("write bursts", mem_i.wr_log_addr.size(), 3);
    check_burst(1'b0, 0, 'h100, 8);
    check_burst(1'b0, 1, 'h120, 8);
    check_burst(1'b0, 2, 'h140, 4);
    foreach (wr_q[i]) begin
      check_eq("memory word", mem_i.mem[('h100 >> 2) + i], wr_q[i]);
    end
    finish_test("write_path", e);
  endtask

  task automatic test_read_path();
    int e = errors;
    read_job(16'h0100, 20);
    check_rx(wr_q);
    check_eq("read bursts", mem_i.rd_log_addr.size(), 3);
    check_burst(1'b1, 0, 'h100, 8);
    check_burst(1'b1, 1, 'h120, 8);
    check_burst(1'b1, 2, 'h140, 4);
    finish_test("read_path", e);
  endtask

  task automatic test_page_split();
    int e = errors;
    make_words(10, split_q);
    write_job(16'h0ff4, split_q);
    check_eq("write bursts", mem_i.wr_log_addr.size(), 5);
    check_burst(1'b0, 3, 'hff4, 3);
    check_burst(1'b0, 4, 'h1000, 7);
    read_job(16'h0ff4, 10);
    check_rx(split_q);
    check_eq("read bursts", mem_i.rd_log_addr.size(), 5);
    check_burst(1'b1, 3, 'hff4, 3);
    check_burst(1'b1, 4, 'h1000, 7);
    finish_test("page_split", e);
  endtask

  task automatic test_backpressure();
    int    e = errors;
    word_t exp[$];
    int    idx;
    // Untouched region still holds the model's fill pattern
    for (int i = 0; i < 30; i++) begin
      idx = ('h2000 >> 2) + i;
      exp.push_back({16'(idx) ^ 16'hc3a5, 16'(idx)});
    end
    rand_ready = 1'b1;
    read_job(16'h2000, 30);
    rand_ready = 1'b0;
    check_rx(exp);
    check_eq("read bursts", mem_i.rd_log_addr.size(), 9);
    check_burst(1'b1, 5, 'h2000, 8);
    check_burst(1'b1, 6, 'h2020, 8);
    check_burst(1'b1, 7, 'h2040, 8);
    check_burst(1'b1, 8, 'h2060, 6);
    finish_test("backpressure", e);
  endtask

  initial begin
    rst_n = 1'b0;
    cfg_in = '0;
    cfg_in_valid = 1'b0;
    cfg_out = '0;
    cfg_out_valid = 1'b0;
    in_data = '0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    rand_ready = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_zero_length();
    test_write_path();
    test_read_path();
    test_page_split();
    test_backpressure();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
source/axis2axi_pkg.sv
source/axis2axi_burst_calc.sv
source/axis2axi_fifo.sv
source/axis2axi_in.sv
source/axis2axi_out.sv
source/axis2axi.sv
bench/axi_mem_model.sv
bench/axis2axi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the axis2axi testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module axis2axi_tb -o sim_axis2axi
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_axis2axi)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
